/* Bender.yml */
package:
  name: lsu_top

sources:
  - lsu_pkg.sv
  - mem_cmd_if.sv
  - agu_stage.sv
  - data_sram.sv
  - lsu.sv
  - wb_regfile.sv
  - lsu_top.sv
  - target: test
    files:
      - tb_lsu_top.sv

/* agu_stage.sv */
/*
 * address generation stage
 * forms base + offset, registers the memory command and pulses valid
 */
`timescale 1ns/1ps
`default_nettype none

module agu_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cmd_valid_i,
    input  logic [lsu_pkg::XLEN-1:0] base_i,
    input  logic [lsu_pkg::XLEN-1:0] offset_i,
    input  logic [lsu_pkg::XLEN-1:0] wdata_i,
    input  lsu_pkg::load_type_e      load_type_i,
    input  lsu_pkg::store_type_e     store_type_i,
    input  logic [4:0]               rd_i,
    mem_cmd_if.producer              cmd
);
    import lsu_pkg::*;

    logic     accept;
    mem_cmd_t next_cmd;

    // new commands are dropped while the unit is busy
    assign accept = cmd_valid_i && !cmd.busy;

    always_comb begin
        next_cmd.addr       = base_i + offset_i;
        next_cmd.wdata      = wdata_i;
        next_cmd.load_type  = load_type_i;
        next_cmd.store_type = store_type_i;
        next_cmd.rd         = rd_i;
        // only loads write back
        next_cmd.wb_en      = (load_type_i != LOAD_NONE);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd.valid <= 1'b0;
        end else begin
            cmd.valid <= accept;
        end
    end

    // payload held until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd.cmd <= next_cmd;
        end
    end

    // upstream must wait for busy to drop
    a_no_valid_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        cmd_valid_i |-> !cmd.busy
    ) else $error("command offered while load/store unit busy");

    // a registered command is either a load or a store, never both
    a_load_xor_store: assert property (
        @(posedge clk) disable iff (rst)
        cmd.valid |-> (cmd.cmd.load_type == LOAD_NONE ||
                       cmd.cmd.store_type == STORE_NONE)
    ) else $error("command carries both a load and a store type");

endmodule

`default_nettype wire

/* data_sram.sv */
/*
 * data SRAM
 * word-organised memory, byte-lane write mask, asynchronous read
 */
`timescale 1ns/1ps
`default_nettype none

module data_sram (
    input  logic                       clk,
    input  logic                       we_i,
    input  logic [3:0]                 wmask_i,
    input  logic [lsu_pkg::MEM_AW-1:0] addr_i,
    input  logic [31:0]                wdata_i,
    output logic [31:0]                rdata_o
);
    import lsu_pkg::*;

    // contents come up undefined
    logic [31:0] mem [MEM_WORDS];

    // only enabled lanes change
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wmask_i[lane]) begin
                    mem[addr_i][8*lane +: 8] <= wdata_i[8*lane +: 8];
                end
            end
        end
    end

    // combinational read of the whole word
    assign rdata_o = mem[addr_i];

    // the controller clears the mask outside the access cycle
    a_mask_idle_zero: assert property (
        @(posedge clk)
        !we_i |-> (wmask_i == 4'b0000)
    ) else $error("byte mask active without write enable");

endmodule

`default_nettype wire

/* lsu.sv */
/*
 * load/store unit
 * three-state controller over the data SRAM, store lane masking,
 * load lane select with sign or zero extension, result register
 */
`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  logic                     clk,
    input  logic                     rst,
    mem_cmd_if.consumer              cmd,
    output logic                     wb_valid_o,
    output logic [4:0]               wb_rd_o,
    output logic [lsu_pkg::XLEN-1:0] wb_data_o,
    output logic                     done_o
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ACCESS = 2'd1,
        DONE   = 2'd2
    } state_e;

    state_e          state_q;
    state_e          state_d;
    mem_cmd_t        cmd_q;
    logic [XLEN-1:0] result_q;
    logic [1:0]      lane;
    logic            is_store;
    logic            sram_we;
    logic [3:0]      st_mask;
    logic [31:0]     st_data;
    logic [31:0]     sram_rdata;
    logic [31:0]     rd_shifted;
    logic [XLEN-1:0] ld_data;
    logic            misaligned;

    // controller
    always_comb begin
        case (state_q)
            IDLE:    state_d = cmd.valid ? ACCESS : IDLE;
            ACCESS:  state_d = DONE;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // capture the command when it is taken
    always_ff @(posedge clk) begin
        if (state_q == IDLE && cmd.valid) begin
            cmd_q <= cmd.cmd;
        end
    end

    assign lane     = cmd_q.addr[1:0];
    assign is_store = (cmd_q.store_type != STORE_NONE);
    assign sram_we  = (state_q == ACCESS) && is_store;

    // store mask and lane-replicated data, mask picks the lanes
    always_comb begin
        case (cmd_q.store_type)
            STORE_SB: begin
                st_mask = MASK_8 << lane;
                st_data = {4{cmd_q.wdata[7:0]}};
            end
            STORE_SH: begin
                st_mask = MASK_16 << lane;
                st_data = {2{cmd_q.wdata[15:0]}};
            end
            STORE_SW: begin
                st_mask = MASK_32;
                st_data = cmd_q.wdata;
            end
            default: begin
                st_mask = 4'b0000;
                st_data = cmd_q.wdata;
            end
        endcase
    end

    data_sram i_data_sram (
        .clk     (clk),
        .we_i    (sram_we),
        .wmask_i (sram_we ? st_mask : 4'b0000),
        .addr_i  (cmd_q.addr[MEM_AW+1:2]),
        .wdata_i (st_data),
        .rdata_o (sram_rdata)
    );

    // bring the addressed lane down to bit 0
    assign rd_shifted = sram_rdata >> {lane, 3'b000};

    always_comb begin
        case (cmd_q.load_type)
            LOAD_LB:  ld_data = {{(XLEN-8){rd_shifted[7]}}, rd_shifted[7:0]};
            LOAD_LBU: ld_data = {{(XLEN-8){1'b0}}, rd_shifted[7:0]};
            LOAD_LH:  ld_data = {{(XLEN-16){rd_shifted[15]}}, rd_shifted[15:0]};
            LOAD_LHU: ld_data = {{(XLEN-16){1'b0}}, rd_shifted[15:0]};
            LOAD_LW:  ld_data = sram_rdata;
            default:  ld_data = '0;
        endcase
    end

    // result latched at the end of the access cycle
    always_ff @(posedge clk) begin
        if (state_q == ACCESS) begin
            result_q <= ld_data;
        end
    end

    assign cmd.busy   = (state_q != IDLE);
    assign done_o     = (state_q == DONE);
    assign wb_valid_o = (state_q == DONE);
    assign wb_rd_o    = cmd_q.rd;
    assign wb_data_o  = result_q;

    // halfword needs bit 0 clear, word needs both low bits clear
    assign misaligned =
        ((cmd_q.load_type == LOAD_LH || cmd_q.load_type == LOAD_LHU ||
          cmd_q.store_type == STORE_SH) && cmd_q.addr[0]) ||
        ((cmd_q.load_type == LOAD_LW || cmd_q.store_type == STORE_SW) &&
         (cmd_q.addr[1:0] != 2'b00));

    a_aligned_access: assert property (
        @(posedge clk) disable iff (rst)
        (state_q == ACCESS) |-> !misaligned
    ) else $error("misaligned memory access");

    a_legal_state: assert property (
        @(posedge clk) disable iff (rst)
        state_q inside {IDLE, ACCESS, DONE}
    ) else $error("load/store controller in undefined state");

endmodule

`default_nettype wire

/* lsu_pkg.sv */
/*
 * lsu package
 * load/store encodings, byte-lane masks, memory sizing and the
 * command record passed from the address stage to the load/store unit
 */
`default_nettype none

package lsu_pkg;

    // datapath width
    localparam int XLEN = 32;

    // data memory sizing, in 32-bit words
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;

    // byte enables for the lowest lanes, shifted up by addr[1:0]
    localparam logic [3:0] MASK_8  = 4'b0001;
    localparam logic [3:0] MASK_16 = 4'b0011;
    localparam logic [3:0] MASK_32 = 4'b1111;

    // load kinds, signed and unsigned variants for byte and half
    typedef enum logic [2:0] {
        LOAD_NONE = 3'd0,
        LOAD_LB   = 3'd1,
        LOAD_LH   = 3'd2,
        LOAD_LW   = 3'd3,
        LOAD_LBU  = 3'd4,
        LOAD_LHU  = 3'd5
    } load_type_e;

    // store kinds
    typedef enum logic [1:0] {
        STORE_NONE = 2'd0,
        STORE_SB   = 2'd1,
        STORE_SH   = 2'd2,
        STORE_SW   = 2'd3
    } store_type_e;

    // one memory command
    // wb_en is set for loads only
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        load_type_e      load_type;
        store_type_e     store_type;
        logic [4:0]      rd;
        logic            wb_en;
    } mem_cmd_t;

endpackage

`default_nettype wire

/* lsu_top.sv */
/*
 * memory stage top
 * address stage, load/store unit and writeback register file
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cmd_valid_i,
    input  logic [lsu_pkg::XLEN-1:0] base_i,
    input  logic [lsu_pkg::XLEN-1:0] offset_i,
    input  logic [lsu_pkg::XLEN-1:0] wdata_i,
    input  lsu_pkg::load_type_e      load_type_i,
    input  lsu_pkg::store_type_e     store_type_i,
    input  logic [4:0]               rd_i,
    output logic                     busy_o,
    output logic                     done_o,
    input  logic [4:0]               rf_raddr_i,
    output logic [lsu_pkg::XLEN-1:0] rf_rdata_o
);

    logic                     wb_valid;
    logic [4:0]               wb_rd;
    logic [lsu_pkg::XLEN-1:0] wb_data;
    logic                     rf_we;

    mem_cmd_if i_cmd_if ();

    agu_stage i_agu_stage (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid_i  (cmd_valid_i),
        .base_i       (base_i),
        .offset_i     (offset_i),
        .wdata_i      (wdata_i),
        .load_type_i  (load_type_i),
        .store_type_i (store_type_i),
        .rd_i         (rd_i),
        .cmd          (i_cmd_if.producer)
    );

    lsu i_lsu (
        .clk        (clk),
        .rst        (rst),
        .cmd        (i_cmd_if.consumer),
        .wb_valid_o (wb_valid),
        .wb_rd_o    (wb_rd),
        .wb_data_o  (wb_data),
        .done_o     (done_o)
    );

    // command stays registered through DONE, so wb_en is still valid here
    assign rf_we  = wb_valid & i_cmd_if.cmd.wb_en;
    assign busy_o = i_cmd_if.busy;

    wb_regfile i_wb_regfile (
        .clk     (clk),
        .rst     (rst),
        .we_i    (rf_we),
        .waddr_i (wb_rd),
        .wdata_i (wb_data),
        .raddr_i (rf_raddr_i),
        .rdata_o (rf_rdata_o)
    );

endmodule

`default_nettype wire

/* mem_cmd_if.sv */
/*
 * memory command link
 * carries one command from the address stage to the load/store unit
 */
`timescale 1ns/1ps
`default_nettype none

interface mem_cmd_if;
    import lsu_pkg::*;

    // one-cycle strobe, cmd is held until the next accept
    logic     valid;
    mem_cmd_t cmd;
    // high while the unit works on a command
    logic     busy;

    modport producer (
        output valid,
        output cmd,
        input  busy
    );

    modport consumer (
        input  valid,
        input  cmd,
        output busy
    );

endinterface

`default_nettype wire

/* sim.f */
lsu_pkg.sv
mem_cmd_if.sv
agu_stage.sv
data_sram.sv
lsu.sv
wb_regfile.sv
lsu_top.sv
tb_lsu_top.sv

/* tb_lsu_top.sv */
/*
 * testbench for the memory stage top
 * table of loads and stores checked against a byte-array memory model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;
    import lsu_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int DONE_LATENCY = 3;
    localparam int MAX_WAIT     = 20;

    typedef struct {
        string       name;
        logic [31:0] base;
        logic [31:0] offset;
        logic [31:0] wdata;
        load_type_e  lt;
        store_type_e st;
        logic [4:0]  rd;
        logic [31:0] expected;
    } entry_t;

    logic        clk;
    logic        rst;
    logic        cmd_valid_i;
    logic [31:0] base_i;
    logic [31:0] offset_i;
    logic [31:0] wdata_i;
    load_type_e  load_type_i;
    store_type_e store_type_i;
    logic [4:0]  rd_i;
    logic        busy_o;
    logic        done_o;
    logic [4:0]  rf_raddr_i;
    logic [31:0] rf_rdata_o;

    entry_t      table_q [$];
    bit          table_ready;
    // byte-level memory and register file models
    logic [7:0]  ref_mem [MEM_WORDS*4];
    logic [31:0] shadow_rf [32];

    lsu_top i_lsu_top (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid_i  (cmd_valid_i),
        .base_i       (base_i),
        .offset_i     (offset_i),
        .wdata_i      (wdata_i),
        .load_type_i  (load_type_i),
        .store_type_i (store_type_i),
        .rd_i         (rd_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .rf_raddr_i   (rf_raddr_i),
        .rf_rdata_o   (rf_rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // append one command, running it through the models for the expected value
    task automatic add_entry(string name, logic [31:0] base, logic [31:0] offset,
                             logic [31:0] wdata, load_type_e lt, store_type_e st,
                             logic [4:0] rd);
        entry_t      e;
        int          a;
        logic [31:0] value;
        a = int'(((base + offset) & 32'h3ff));
        value = '0;
        case (st)
            STORE_SB: ref_mem[a] = wdata[7:0];
            STORE_SH: for (int i = 0; i < 2; i++) ref_mem[a+i] = wdata[8*i +: 8];
            STORE_SW: for (int i = 0; i < 4; i++) ref_mem[a+i] = wdata[8*i +: 8];
            default: ;
        endcase
        case (lt)
            LOAD_LB:  value = {{24{ref_mem[a][7]}}, ref_mem[a]};
            LOAD_LBU: value = {24'h0, ref_mem[a]};
            LOAD_LH:  value = {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
            LOAD_LHU: value = {16'h0, ref_mem[a+1], ref_mem[a]};
            LOAD_LW:  value = {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
            default: ;
        endcase
        // x0 never changes, stores never write back
        if (lt != LOAD_NONE && rd != 5'd0) begin
            shadow_rf[rd] = value;
        end
        e = '{name, base, offset, wdata, lt, st, rd, shadow_rf[rd]};
        table_q.push_back(e);
    endtask

    // one word store, a random partial store and a random load per word
    task automatic build_sweep();
        logic [31:0] off;
        int unsigned pick;
        int unsigned lane;
        store_type_e st;
        load_type_e  lt;
        for (int w = 0; w < MEM_WORDS; w++) begin
            off = $urandom() & 32'h7c;
            add_entry($sformatf("sweep_sw_%0d", w), 32'(w * 4) - off, off, $urandom(),
                      LOAD_NONE, STORE_SW, 5'($urandom()));
            pick = $urandom() % 3;
            case (pick)
                0: st = STORE_SB;
                1: st = STORE_SH;
                default: st = STORE_SW;
            endcase
            lane = $urandom() & ((pick == 0) ? 3 : (pick == 1) ? 2 : 0);
            add_entry($sformatf("sweep_st_%0d", w), 32'(w * 4), lane, $urandom(),
                      LOAD_NONE, st, 5'($urandom()));
            pick = $urandom() % 5;
            case (pick)
                0: lt = LOAD_LB;
                1: lt = LOAD_LBU;
                2: lt = LOAD_LH;
                3: lt = LOAD_LHU;
                default: lt = LOAD_LW;
            endcase
            lane = $urandom() & ((pick < 2) ? 3 : (pick < 4) ? 2 : 0);
            add_entry($sformatf("sweep_ld_%0d", w), 32'(w * 4), lane, 32'h0,
                      lt, STORE_NONE, 5'($urandom()));
        end
    endtask

    task automatic build_table();
        add_entry("sw_word", 32'h100, 32'h0, 32'hdeadbeef, LOAD_NONE, STORE_SW, 5'd0);
        add_entry("lw_word", 32'h0f0, 32'h10, 32'h0, LOAD_LW, STORE_NONE, 5'd5);
        add_entry("sw_merge", 32'h200, 32'h0, 32'h11223344, LOAD_NONE, STORE_SW, 5'd5);
        for (int lane = 0; lane < 4; lane++) begin
            add_entry($sformatf("sb_lane%0d", lane), 32'h200, lane,
                      32'hffffff00 | (32'ha0 + lane), LOAD_NONE, STORE_SB, 5'd5);
            add_entry($sformatf("lw_after_sb%0d", lane), 32'h200, 32'h0, 32'h0,
                      LOAD_LW, STORE_NONE, 5'd6);
        end
        add_entry("sh_lane0", 32'h200, 32'h0, 32'hffff5566, LOAD_NONE, STORE_SH, 5'd6);
        add_entry("lw_after_sh0", 32'h200, 32'h0, 32'h0, LOAD_LW, STORE_NONE, 5'd7);
        add_entry("sh_lane2", 32'h200, 32'h2, 32'hcafe7788, LOAD_NONE, STORE_SH, 5'd7);
        add_entry("lw_after_sh2", 32'h200, 32'h0, 32'h0, LOAD_LW, STORE_NONE, 5'd7);
        // bytes 81 7f ff 80 from lane 0 up, negative offset
        add_entry("sw_signs", 32'h310, 32'hfffffff0, 32'h80ff7f81, LOAD_NONE, STORE_SW, 5'd8);
        add_entry("lb_neg", 32'h300, 32'h0, 32'h0, LOAD_LB, STORE_NONE, 5'd8);
        add_entry("lbu_neg", 32'h300, 32'h0, 32'h0, LOAD_LBU, STORE_NONE, 5'd9);
        add_entry("lb_pos", 32'h300, 32'h1, 32'h0, LOAD_LB, STORE_NONE, 5'd10);
        add_entry("lb_lane3", 32'h300, 32'h3, 32'h0, LOAD_LB, STORE_NONE, 5'd11);
        add_entry("lh_neg", 32'h300, 32'h2, 32'h0, LOAD_LH, STORE_NONE, 5'd12);
        add_entry("lhu_neg", 32'h300, 32'h2, 32'h0, LOAD_LHU, STORE_NONE, 5'd13);
        add_entry("lh_pos", 32'h300, 32'h0, 32'h0, LOAD_LH, STORE_NONE, 5'd14);
        add_entry("lw_rd0", 32'h300, 32'h0, 32'h0, LOAD_LW, STORE_NONE, 5'd0);
        build_sweep();
    endtask

    // called one ns after an edge with busy low
    task automatic apply_entry(entry_t e);
        int cycles;
        base_i       = e.base;
        offset_i     = e.offset;
        wdata_i      = e.wdata;
        load_type_i  = e.lt;
        store_type_i = e.st;
        rd_i         = e.rd;
        rf_raddr_i   = e.rd;
        cmd_valid_i  = 1'b1;
        @(posedge clk);
        #1;
        cmd_valid_i = 1'b0;
        cycles = 1;
        while (done_o !== 1'b1) begin
            check_value({e.name, " busy"}, 32'(cycles > 1), 32'(busy_o));
            if (cycles >= MAX_WAIT) begin
                $display("no done pulse for %s within %0d cycles", e.name, MAX_WAIT);
                $display("CHECKS FAILED");
                $fatal(1, "done never arrived");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        check_value({e.name, " latency"}, DONE_LATENCY, cycles);
        check_value({e.name, " busy at done"}, 32'd1, 32'(busy_o));
        @(posedge clk);
        #1;
        check_value(e.name, e.expected, rf_rdata_o);
        check_value({e.name, " busy after"}, 32'd0, 32'(busy_o));
    endtask

    initial begin
        wait (table_ready);
        // each command takes four cycles, ten leaves margin
        repeat (table_q.size() * 10 + RESET_CYCLES + 20) @(posedge clk);
        $display("timeout, the stimulus table did not finish in time");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst          = 1'b1;
        cmd_valid_i  = 1'b0;
        base_i       = '0;
        offset_i     = '0;
        wdata_i      = '0;
        load_type_i  = LOAD_NONE;
        store_type_i = STORE_NONE;
        rd_i         = '0;
        rf_raddr_i   = '0;
        void'($urandom(32'h21e3));
        for (int i = 0; i < 32; i++) begin
            shadow_rf[i] = '0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("reset busy", 32'd0, 32'(busy_o));
        check_value("reset done", 32'd0, 32'(done_o));
        foreach (table_q[i]) begin
            apply_entry(table_q[i]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* wb_regfile.sv */
/*
 * writeback register file
 * 32 x XLEN registers, x0 hard-wired to zero, one combinational read port
 */
`timescale 1ns/1ps
`default_nettype none

module wb_regfile (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     we_i,
    input  logic [4:0]               waddr_i,
    input  logic [lsu_pkg::XLEN-1:0] wdata_i,
    input  logic [4:0]               raddr_i,
    output logic [lsu_pkg::XLEN-1:0] rdata_o
);
    import lsu_pkg::*;

    logic [XLEN-1:0] regs [32];

    // writes to x0 are dropped, so x0 keeps its reset value
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_o = regs[raddr_i];

endmodule

`default_nettype wire
